/* Bender.yml */
package:
  name: exec_core

sources:
  - files:
      - design/rv_isa_pkg.sv
      - design/exec_bus_pkg.sv
      - design/rv_decoder.sv
      - design/rv_regfile.sv
      - design/rv_alu.sv
      - design/exec_bus_regs.sv
      - design/exec_core_top.sv
  - target: test
    files:
      - verif/tb_clock.sv
      - verif/exec_checker.sv
      - verif/exec_bus_sva.sv
      - verif/exec_tb.sv

/* design/exec_bus_pkg.sv */
`default_nettype none

package exec_bus_pkg;

    localparam int bus_adr_w = 12;
    localparam int bus_dat_w = 64;
    localparam int cnt_w     = 32;  // Retired and illegal counters

    localparam logic [bus_adr_w-1:0] addr_instr     = 12'h000;
    localparam logic [bus_adr_w-1:0] addr_status    = 12'h008;
    localparam logic [bus_adr_w-1:0] addr_regs_base = 12'h100;  // x0..x31, 8 bytes apart

    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [bus_adr_w-1:0] adr;
        logic [bus_dat_w-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic                 ack;
        logic [bus_dat_w-1:0] dat;
    } wb_rsp_t;

endpackage

`default_nettype wire

/* design/exec_bus_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module exec_bus_regs
    import rv_isa_pkg::*;
    import exec_bus_pkg::*;
(
    input  wire          clk,
    input  wire          rst,
    input  wire wb_req_t wb_req,
    output wb_rsp_t      wb_rsp,
    output logic [31:0]  instr,
    input  wire          legal,
    output logic         rf_we,
    output reg_addr_t    dbg_addr,
    input  wire xword_t  dbg_data
);

    logic             req_new;
    logic             instr_wr;
    logic             status_hit;
    logic             regs_hit;
    logic [cnt_w-1:0] retired_count;
    logic [cnt_w-1:0] illegal_count;
    xword_t           rd_data;

    ////////////////////////////////////////////////////////////
    // Request decode
    ////////////////////////////////////////////////////////////

    assign req_new    = wb_req.cyc && wb_req.stb && !wb_rsp.ack;  // First edge only
    assign instr_wr   = req_new && wb_req.we && (wb_req.adr == addr_instr);
    assign rf_we      = instr_wr && legal;
    assign instr      = wb_req.dat[31:0];
    assign dbg_addr   = wb_req.adr[7:3];  // One register per 8-byte word
    assign status_hit = (wb_req.adr == addr_status);
    assign regs_hit   = (wb_req.adr[bus_adr_w-1:8] == addr_regs_base[bus_adr_w-1:8]);

    always_comb begin
        if (status_hit) begin
            rd_data = {illegal_count, retired_count};
        end else if (regs_hit) begin
            rd_data = dbg_data;
        end else begin
            rd_data = '0;  // Unmapped
        end
    end

    ////////////////////////////////////////////////////////////
    // Response and counters
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_rsp.ack <= 1'b0;
            wb_rsp.dat <= '0;
        end else begin
            wb_rsp.ack <= req_new;  // Single-cycle ack, no wait states
            if (req_new && !wb_req.we) begin
                wb_rsp.dat <= rd_data;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            retired_count <= '0;
            illegal_count <= '0;
        end else if (instr_wr) begin
            if (legal) begin
                retired_count <= retired_count + 1'b1;
            end else begin
                illegal_count <= illegal_count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* design/exec_core_top.sv */
`timescale 1ns/1ns
`default_nettype none

module exec_core_top
    import rv_isa_pkg::*;
    import exec_bus_pkg::*;
(
    input  wire          clk,
    input  wire          rst,
    input  wire wb_req_t wb_req,
    output wb_rsp_t      wb_rsp
);

    logic [31:0] instr;
    exec_op_t    op;
    xword_t      rs1_data;
    xword_t      rs2_data;
    xword_t      alu_result;
    xword_t      dbg_data;
    reg_addr_t   dbg_addr;
    logic        rf_we;

    exec_bus_regs bus_i (
        .clk      (clk),
        .rst      (rst),
        .wb_req   (wb_req),
        .wb_rsp   (wb_rsp),
        .instr    (instr),
        .legal    (op.legal),
        .rf_we    (rf_we),
        .dbg_addr (dbg_addr),
        .dbg_data (dbg_data)
    );

    rv_decoder dec_i (
        .instr (instr),
        .op    (op)
    );

    rv_regfile rf_i (
        .clk      (clk),
        .rst      (rst),
        .rs1_addr (op.rs1),
        .rs2_addr (op.rs2),
        .dbg_addr (dbg_addr),
        .we       (rf_we),
        .wr_addr  (op.rd),
        .wr_data  (alu_result),  // Written back on the ack edge
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .dbg_data (dbg_data)
    );

    rv_alu alu_i (
        .op       (op),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .result   (alu_result)
    );

endmodule

`default_nettype wire

/* design/rv_alu.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_alu
    import rv_isa_pkg::*;
(
    input  wire exec_op_t op,
    input  wire xword_t   rs1_data,
    input  wire xword_t   rs2_data,
    output xword_t        result
);

    xword_t     opa;
    xword_t     opb;
    logic [5:0] shamt;
    xword_t     diff;
    logic       lt_signed;
    logic       lt_unsigned;

    ////////////////////////////////////////////////////////////
    // Operand select
    ////////////////////////////////////////////////////////////

    assign opa   = rs1_data;
    assign opb   = op.use_imm ? op.imm : rs2_data;
    assign shamt = opb[5:0];  // RV64 uses six shift bits

    assign diff        = opa - opb;
    assign lt_signed   = $signed(opa) < $signed(opb);
    assign lt_unsigned = opa < opb;

    ////////////////////////////////////////////////////////////
    // Result mux
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (op.alu_op)
            alu_add:  result = opa + opb;
            alu_sub:  result = diff;
            alu_sll:  result = opa << shamt;
            alu_slt:  result = {{(xlen-1){1'b0}}, lt_signed};
            alu_sltu: result = {{(xlen-1){1'b0}}, lt_unsigned};
            alu_xor:  result = opa ^ opb;
            alu_srl:  result = opa >> shamt;
            alu_sra:  result = $signed(opa) >>> shamt;  // Sign fill
            alu_or:   result = opa | opb;
            alu_and:  result = opa & opb;
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* design/rv_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_decoder
    import rv_isa_pkg::*;
(
    input  wire [31:0] instr,
    output exec_op_t   op
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [5:0] shift_hi;  // imm[11:6] of an immediate shift
    logic       is_op;
    logic       alt_sel;

    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign funct7   = instr[31:25];
    assign shift_hi = instr[31:26];
    assign is_op    = (opcode == opcode_op);
    assign alt_sel  = is_op ? (funct7 == funct7_alt) : (shift_hi == shift_hi_alt);

    always_comb begin
        op.rd      = instr[11:7];
        op.rs1     = instr[19:15];
        op.rs2     = instr[24:20];
        op.imm     = {{(xlen-12){instr[31]}}, instr[31:20]};
        op.use_imm = (opcode == opcode_op_imm);

        case (funct3)
            funct3_add:  op.alu_op = (is_op && alt_sel) ? alu_sub : alu_add;  // No subi
            funct3_sll:  op.alu_op = alu_sll;
            funct3_slt:  op.alu_op = alu_slt;
            funct3_sltu: op.alu_op = alu_sltu;
            funct3_xor:  op.alu_op = alu_xor;
            funct3_sr:   op.alu_op = alt_sel ? alu_sra : alu_srl;
            funct3_or:   op.alu_op = alu_or;
            default:     op.alu_op = alu_and;
        endcase

        // Only the two integer opcodes with valid upper fields are accepted
        op.legal = 1'b0;
        if (is_op) begin
            op.legal = (funct7 == 7'h00) ||
                       ((funct7 == funct7_alt) && (funct3 == funct3_add || funct3 == funct3_sr));
        end else if (opcode == opcode_op_imm) begin
            case (funct3)
                funct3_sll: op.legal = (shift_hi == 6'h00);
                funct3_sr:  op.legal = (shift_hi == 6'h00) || (shift_hi == shift_hi_alt);
                default:    op.legal = 1'b1;
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    localparam int xlen  = 64;
    localparam int nregs = 32;

    typedef logic [$clog2(nregs)-1:0] reg_addr_t;
    typedef logic [xlen-1:0]          xword_t;

    ////////////////////////////////////////////////////////////
    // Opcodes and function fields
    ////////////////////////////////////////////////////////////

    localparam logic [6:0] opcode_op     = 7'b0110011;  // Register-register
    localparam logic [6:0] opcode_op_imm = 7'b0010011;  // Register-immediate

    localparam logic [2:0] funct3_add  = 3'b000;
    localparam logic [2:0] funct3_sll  = 3'b001;
    localparam logic [2:0] funct3_slt  = 3'b010;
    localparam logic [2:0] funct3_sltu = 3'b011;
    localparam logic [2:0] funct3_xor  = 3'b100;
    localparam logic [2:0] funct3_sr   = 3'b101;  // srl and sra share this code
    localparam logic [2:0] funct3_or   = 3'b110;
    localparam logic [2:0] funct3_and  = 3'b111;

    localparam logic [6:0] funct7_alt    = 7'h20;  // Selects sub and sra
    localparam logic [5:0] shift_hi_alt  = 6'h10;  // imm[11:6] for srai

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

    typedef struct packed {
        alu_op_t   alu_op;
        logic      use_imm;  // Second operand from imm
        xword_t    imm;      // Sign-extended I-immediate
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        logic      legal;
    } exec_op_t;

endpackage

`default_nettype wire

/* design/rv_regfile.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_regfile
    import rv_isa_pkg::*;
(
    input  wire            clk,
    input  wire            rst,
    input  wire reg_addr_t rs1_addr,
    input  wire reg_addr_t rs2_addr,
    input  wire reg_addr_t dbg_addr,
    input  wire            we,
    input  wire reg_addr_t wr_addr,
    input  wire xword_t    wr_data,
    output xword_t         rs1_data,
    output xword_t         rs2_data,
    output xword_t         dbg_data
);

    xword_t regs [nregs];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < nregs; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wr_addr != '0) begin  // x0 is never written
            regs[wr_addr] <= wr_data;
        end
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];
    assign dbg_data = (dbg_addr == '0) ? '0 : regs[dbg_addr];  // Host port

endmodule

`default_nettype wire

/* filelist.f */
design/rv_isa_pkg.sv
design/exec_bus_pkg.sv
design/rv_decoder.sv
design/rv_regfile.sv
design/rv_alu.sv
design/exec_bus_regs.sv
design/exec_core_top.sv
verif/tb_clock.sv
verif/exec_checker.sv
verif/exec_bus_sva.sv
verif/exec_tb.sv

/* verif/exec_bus_sva.sv */
`timescale 1ns/1ns
`default_nettype none

module exec_bus_sva
    import exec_bus_pkg::*;
(
    input wire          clk,
    input wire          rst,
    input wire wb_req_t wb_req,
    input wire wb_rsp_t wb_rsp,
    input wire          rf_we
);

    int fail_count = 0;

    ack_single: assert property (@(posedge clk) disable iff (rst) wb_rsp.ack |=> !wb_rsp.ack)
        else begin
            $error("ack held high for two cycles");
            fail_count++;
        end

    ack_after_req: assert property (@(posedge clk) disable iff (rst)
        $rose(wb_rsp.ack) |-> $past(wb_req.cyc && wb_req.stb))
        else begin
            $error("ack rose without cyc and stb");
            fail_count++;
        end

    we_with_ack: assert property (@(posedge clk) disable iff (rst)
        rf_we |-> !wb_rsp.ack ##1 wb_rsp.ack)  // Write lands on the ack edge
        else begin
            $error("register write outside an ack cycle");
            fail_count++;
        end

endmodule

bind exec_bus_regs exec_bus_sva sva_i (
    .clk    (clk),
    .rst    (rst),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp),
    .rf_we  (rf_we)
);

`default_nettype wire

/* verif/exec_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module exec_checker
    import rv_isa_pkg::*;
    import exec_bus_pkg::*;
(
    input  wire          clk,
    input  wire          rst,
    input  wire wb_req_t wb_req,
    input  wire wb_rsp_t wb_rsp,
    output int           errors
);

    xword_t         model [nregs];  // x0 is never written
    logic [31:0]    retired;
    logic [31:0]    illegal;
    logic           ack_due;
    logic           rd_pend;
    logic [11:0]    rd_adr;
    xword_t         rd_exp;
    xword_t         res;

    // Reference execution of one instruction word, returns 1 for a kept encoding
    function automatic logic run_instr(input logic [31:0] w, output xword_t r);
        xword_t a;
        xword_t b;
        logic   imm_form;
        logic   alt;
        a        = model[w[19:15]];
        imm_form = (w[6:0] == 7'h13);
        b        = imm_form ? {{52{w[31]}}, w[31:20]} : model[w[24:20]];
        alt      = imm_form ? (w[31:26] == 6'h10) : (w[31:25] == 7'h20);
        case (w[14:12])
            3'd0:    r = (alt && !imm_form) ? a - b : a + b;
            3'd1:    r = a << b[5:0];
            3'd2:    r = xword_t'($signed(a) < $signed(b));
            3'd3:    r = xword_t'(a < b);
            3'd4:    r = a ^ b;
            3'd5:    r = alt ? xword_t'($signed(a) >>> b[5:0]) : a >> b[5:0];
            3'd6:    r = a | b;
            default: r = a & b;
        endcase
        if (imm_form) begin
            return (w[14:12] == 3'd1) ? (w[31:26] == 6'h00) :
                   (w[14:12] == 3'd5) ? (w[31:26] == 6'h00 || alt) : 1'b1;
        end
        return (w[6:0] == 7'h33) &&
               (w[31:25] == 7'h00 || (alt && (w[14:12] == 3'd0 || w[14:12] == 3'd5)));
    endfunction

    initial errors = 0;

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < nregs; i++) begin
                model[i] = '0;
            end
            retired = '0;
            illegal = '0;
            ack_due = 1'b0;
            rd_pend = 1'b0;
        end else begin
            if (ack_due != wb_rsp.ack) begin
                $display("Error: ack %s at %0t", ack_due ? "missing" : "without a request", $time);
                errors++;
            end
            if (wb_rsp.ack && rd_pend && wb_rsp.dat !== rd_exp) begin
                $display("mismatch wb_rsp.dat adr 0x%h expected 0x%h actual 0x%h",
                         rd_adr, rd_exp, wb_rsp.dat);
                errors++;
            end
            ack_due = wb_req.cyc && wb_req.stb && !wb_rsp.ack;  // Accepted on this edge
            rd_pend = ack_due && !wb_req.we;
            rd_adr  = wb_req.adr;
            if (ack_due && wb_req.we && wb_req.adr == addr_instr) begin
                if (run_instr(wb_req.dat[31:0], res)) begin
                    if (wb_req.dat[11:7] != 5'd0) begin
                        model[wb_req.dat[11:7]] = res;
                    end
                    retired++;
                end else begin
                    illegal++;  // Nothing written
                end
            end
            rd_exp = (wb_req.adr == addr_status) ? {illegal, retired} :
                     (wb_req.adr[11:8] == 4'h1) ? model[wb_req.adr[7:3]] : '0;
        end
    end

endmodule

`default_nettype wire

/* verif/exec_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module exec_tb
    import rv_isa_pkg::*;
    import exec_bus_pkg::*;
();

    logic    clk;
    logic    rst;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;
    int      errors;
    int      timeouts;
    int      sva_fails;

    tb_clock clock_i (.clk, .rst);
    exec_core_top dut_i (.clk, .rst, .wb_req, .wb_rsp);
    exec_checker check_i (.clk, .rst, .wb_req, .wb_rsp, .errors);

    ////////////////////////////////////////////////////////////
    // Bus access and instruction generation
    ////////////////////////////////////////////////////////////

    task automatic bus_cycle(input logic we, input logic [bus_adr_w-1:0] adr, input xword_t dat);
        int waited;
        waited = 0;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        @(negedge clk);
        while (!wb_rsp.ack && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        if (!wb_rsp.ack) begin
            $display("Error: ack never arrived for the access at 0x%h", adr);
            timeouts++;
        end
        wb_req = '0;
        @(negedge clk);  // Idle cycle between requests
    endtask

    task automatic read_reg(input int r);
        bus_cycle(1'b0, addr_regs_base + (12'(r) << 3), '0);
    endtask

    function automatic logic [31:0] rand_legal();
        logic [31:0] w;
        logic        alt;
        logic        op_form;
        w       = $urandom;
        alt     = w[1];
        op_form = w[0];
        if (op_form) begin
            w[6:0]   = 7'h33;
            w[31:25] = (alt && (w[14:12] == 3'd0 || w[14:12] == 3'd5)) ? 7'h20 : 7'h00;
        end else begin
            w[6:0] = 7'h13;
            if (w[14:12] == 3'd1 || w[14:12] == 3'd5) begin
                w[31:26] = (alt && w[14:12] == 3'd5) ? 6'h10 : 6'h00;  // slli, srli, srai
            end
        end
        return w;
    endfunction

    function automatic logic [31:0] rand_illegal();
        logic [31:0] w;
        w = $urandom;
        case (w[1:0])
            2'd0: begin
                w[6:0]   = 7'h33;
                w[31:25] = 7'h01;  // Reserved funct7
            end
            2'd1: begin
                w[6:0]   = 7'h33;
                w[31:25] = 7'h20;
                if (w[14:12] == 3'd0 || w[14:12] == 3'd5) begin
                    w[14:12] = 3'd4;  // Alternate funct7 outside sub and sra
                end
            end
            2'd2: begin
                w[6:0]   = 7'h13;
                w[14:12] = w[12] ? 3'd5 : 3'd1;
                w[26]    = 1'b1;  // Shift upper bits neither zero nor srai
            end
            default: begin
                w[0] = 1'b0;  // Never OP or OP-IMM
            end
        endcase
        return w;
    endfunction

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    initial begin : stim
        int          n;
        logic [31:0] w;
        wb_req   = '0;
        timeouts = 0;
        void'($urandom(32'hebf4c12c));
        n = 0;
        while (rst !== 1'b0 && n < 50) begin
            @(negedge clk);
            n++;
        end
        if (rst !== 1'b0) begin
            $display("Error: reset was never released");
            timeouts++;
        end
        for (int r = 0; r < nregs; r++) begin
            read_reg(r);  // Reset values
        end
        bus_cycle(1'b0, addr_status, '0);
        for (int i = 0; i < 62; i++) begin
            w = {12'($urandom), 5'($urandom), 3'b000, 5'(i % 31 + 1), 7'h13};  // addi chain
            bus_cycle(1'b1, addr_instr, {32'h0, w});
        end
        for (int i = 1; i <= 300; i++) begin
            w = ($urandom % 10 == 0) ? rand_illegal() : rand_legal();
            bus_cycle(1'b1, addr_instr, {32'h0, w});
            read_reg(w[11:7]);
            if (i % 50 == 0) begin
                bus_cycle(1'b0, addr_status, '0);
            end
        end
        for (int r = 0; r < nregs; r++) begin
            read_reg(r);
        end
        sva_fails = dut_i.bus_i.sva_i.fail_count;
        $display("Checks: %0d errors, %0d timeouts, %0d assertion failures",
                 errors, timeouts, sva_fails);
        if (errors == 0 && timeouts == 0 && sva_fails == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/tb_clock.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;  // Released away from the active edge
    end

endmodule

`default_nettype wire
